/* list.f */
verilog/ks10BusPkg.sv
verilog/busArbiter.sv
verilog/busMux.sv
verilog/ubaDevice.sv
verilog/ubaBus.sv
test/ubaBusChecker.sv
test/ubaBusTb.sv

/* test/ubaBusTb.sv */
/*
   UBA backplane testbench
   Random CPU register traffic and DMA strobes from a fixed seed.
   The testbench plays memory with a random ack delay
*/

`timescale 1ns/100ps

module ubaBusTb;

   import ks10BusPkg::*;

   localparam int numOps      = 300;
   localparam int ackLimit    = 100;            // Cycles for one CPU op, NXM included
   localparam int drainLimit  = 1000;
   localparam int quietCycles = 20;             // Memory idle this long means drained
   localparam int summaryWait = 10;

   logic     clk         = 1'b0;
   logic     rst         = 1'b1;
   busCycleT cpuCycle    = '0;
   logic     dmaGo1      = 1'b0;
   logic     dmaGo3      = 1'b0;
   logic     memAck      = 1'b0;
   logic     endRun      = 1'b0;
   logic     cpuAck;
   dataT     cpuRdata;
   logic     cpuNxm;
   busCycleT memCycle;
   int       errorCount;
   logic     summaryDone;
   integer   seed        = 32'h902c_cf82;
   int       memDelay    = 0;                   // Cycles left before memAck
   string    stallReason = "";
   logic     runOk;

   always #5 clk = ~clk;

   ubaBus #(
      .ackTimeout (16)
   ) ubaBus_inst (
      .clk      (clk),
      .rst      (rst),
      .cpuCycle (cpuCycle),
      .cpuAck   (cpuAck),
      .cpuRdata (cpuRdata),
      .cpuNxm   (cpuNxm),
      .dmaGo1   (dmaGo1),
      .dmaGo3   (dmaGo3),
      .memCycle (memCycle),
      .memAck   (memAck)
   );

   ubaBusChecker checker_inst (
      .clk         (clk),
      .rst         (rst),
      .cpuCycle    (cpuCycle),
      .cpuAck      (cpuAck),
      .cpuRdata    (cpuRdata),
      .cpuNxm      (cpuNxm),
      .dmaGo1      (dmaGo1),
      .dmaGo3      (dmaGo3),
      .memCycle    (memCycle),
      .memAck      (memAck),
      .endRun      (endRun),
      .errorCount  (errorCount),
      .summaryDone (summaryDone)
   );

   //////////////////////////////
   // Memory responder
   //////////////////////////////

   always @(posedge clk)
   begin
      if (rst)
      begin
         memAck   <= 1'b0;
         memDelay = 0;
      end
      else
      begin
         memAck <= 1'b0;                        // One cycle pulse
         if (memCycle.req && !memAck)
         begin
            if (memDelay == 0)
               memDelay = 1 + ({$random(seed)} % 8);
            memDelay = memDelay - 1;
            if (memDelay == 0)
               memAck <= 1'b1;
         end
      end
   end

   //////////////////////////////
   // Stimulus helpers
   //////////////////////////////

   // Device 1, 3 or the absent 5, random register, direction and data
   function automatic busCycleT randomCycle();
      busCycleT c;
      int       pick;
      int       dev;
      pick = {$random(seed)} % 3;
      dev  = (pick == 0) ? 1 : (pick == 1) ? 3 : 5;
      c                     = '0;
      c.req                 = 1'b1;
      c.addr[writeBit]      = ({$random(seed)} % 2) == 0;
      c.addr[devField +: 4] = devNumT'(dev);
      c.addr[regField +: 2] = 2'({$random(seed)} % 4);
      c.data                = dataT'({$random(seed), $random(seed)});
      return c;
   endfunction

   // Idle cycles with random DMA strobes
   task automatic strobeGap();
      int gap;
      gap = 1 + ({$random(seed)} % 4);
      repeat (gap)
      begin
         @(posedge clk);
         dmaGo1 <= ({$random(seed)} % 4) == 0;
         dmaGo3 <= ({$random(seed)} % 4) == 0;
      end
      @(posedge clk);
      dmaGo1 <= 1'b0;
      dmaGo3 <= 1'b0;
   endtask

   // Hold the request level until cpuAck
   task automatic cpuOp(input busCycleT cyc, output logic ok);
      int waited;
      waited   = 0;
      cpuCycle <= cyc;
      do
      begin
         @(posedge clk);
         waited++;
      end
      while (!cpuAck && waited < ackLimit);
      ok       = cpuAck;
      cpuCycle <= '0;
   endtask

   task automatic drainDma(output logic ok);
      int quiet;
      int waited;
      quiet  = 0;
      waited = 0;
      while (quiet < quietCycles && waited < drainLimit)
      begin
         @(posedge clk);
         waited++;
         quiet = memCycle.req ? 0 : quiet + 1;
      end
      ok = (quiet >= quietCycles);
   endtask

   task automatic waitSummary(output logic ok);
      int waited;
      waited = 0;
      endRun <= 1'b1;
      do
      begin
         @(posedge clk);
         waited++;
      end
      while (!summaryDone && waited < summaryWait);
      ok = summaryDone;
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial
   begin
      runOk = 1'b1;
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      for (int op = 0; op < numOps && runOk; op++)
      begin
         strobeGap();
         cpuOp(randomCycle(), runOk);
         if (!runOk)
            stallReason = $sformatf("no cpuAck for CPU operation %0d", op);
      end
      if (runOk)
      begin
         drainDma(runOk);                       // Let pending DMAs finish
         if (!runOk)
            stallReason = "memory port never went quiet";
      end
      if (runOk)
      begin
         waitSummary(runOk);
         if (!runOk)
            stallReason = "checker summary never appeared";
      end
      if (runOk && errorCount == 0)
         $display("*** PASSED ***");
      else
      begin
         if (!runOk)
            $display("Run stopped: %s", stallReason);
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

/* test/ubaBusChecker.sv */
/*
   UBA backplane checker
   Register file and DMA model, compares every CPU completion and memory write
*/

`timescale 1ns/100ps

module ubaBusChecker
(
   input  logic                 clk,
   input  logic                 rst,
   input  ks10BusPkg::busCycleT cpuCycle,
   input  logic                 cpuAck,
   input  ks10BusPkg::dataT     cpuRdata,
   input  logic                 cpuNxm,
   input  logic                 dmaGo1,
   input  logic                 dmaGo3,
   input  ks10BusPkg::busCycleT memCycle,
   input  logic                 memAck,
   input  logic                 endRun,         // Stimulus done, traffic drained
   output int                   errorCount,
   output logic                 summaryDone     // Closing line printed
);

   import ks10BusPkg::*;

   localparam int cpuLatency = 3;               // Request edge to cpuAck rising

   dataT regModel [2][4];                       // Index 0 is UBA1, 1 is UBA3
   logic pending  [2];                          // DMA accepted, not yet in memory
   addrT expAddr  [2];                          // Captured when dmaGo is taken
   dataT expData  [2];
   logic reqSeen;                               // CPU cycle outstanding
   addrT reqAddr;
   dataT reqData;
   logic reqTimed;                              // No DMA ahead of it
   int   reqStamp;
   int   cycleNum;
   int   cpuCount;
   int   goCount;
   int   dmaCount;

   task automatic compareValue(input string testName, input logic [35:0] expected,
                               input logic [35:0] actual);
      if (expected !== actual)
      begin
         errorCount++;
         $display("CHECK FAILED %s: expected %h, actual %h", testName, expected, actual);
      end
   endtask

   task automatic reportError(input string what);
      errorCount++;
      $display("ERROR: %s", what);
   endtask

   //////////////////////////////
   // Bus watcher
   //////////////////////////////

   always @(posedge clk)
   begin : watch
      logic   pendBefore [2];
      devNumT dev;
      int     idx;
      int     regSel;
      logic   go;

      if (rst)
      begin
         for (int d = 0; d < 2; d++)
         begin
            for (int r = 0; r < 4; r++)
               regModel[d][r] = '0;             // Registers clear on reset
            pending[d] = 1'b0;
         end
         reqSeen     = 1'b0;
         cycleNum    = 0;
         cpuCount    = 0;
         goCount     = 0;
         dmaCount    = 0;
         errorCount  = 0;
         summaryDone <= 1'b0;
      end
      else
      begin
         cycleNum++;
         pendBefore[0] = pending[0];            // State before this edge
         pendBefore[1] = pending[1];

         // New CPU request, the arbiter samples it on this edge
         if (cpuCycle.req && !reqSeen)
         begin
            reqSeen  = 1'b1;
            reqAddr  = cpuCycle.addr;
            reqData  = cpuCycle.data;
            reqStamp = cycleNum;
            reqTimed = !memCycle.req;           // Arbiter idle here
         end

         // CPU completion
         if (cpuAck)
         begin
            if (!reqSeen)
               reportError("cpuAck with no CPU request outstanding");
            else
            begin
               cpuCount++;
               dev    = reqAddr[devField +: 4];
               regSel = reqAddr[regField +: 2];
               if (dev == 4'd1 || dev == 4'd3)
               begin
                  idx = (dev == 4'd1) ? 0 : 1;
                  compareValue($sformatf("nxm UBA%0d", dev), 36'd0, cpuNxm);
                  if (reqAddr[writeBit])
                     regModel[idx][regSel] = reqData;
                  else
                     compareValue($sformatf("read UBA%0d reg %0d", dev, regSel),
                                  regModel[idx][regSel], cpuRdata);
                  // Ack is seen one sample after it rises
                  if (reqTimed)
                     compareValue("cpu latency", cpuLatency, cycleNum - reqStamp - 1);
               end
               else
               begin
                  compareValue($sformatf("nxm absent dev %0d", dev), 36'd1, cpuNxm);
                  compareValue("rdata absent dev", 36'd0, cpuRdata);
               end
            end
            reqSeen = 1'b0;
         end

         // Memory write commits with memAck
         if (memAck && memCycle.req)
         begin
            dmaCount++;                         // Every write memory takes
            if (pendBefore[0])
               idx = 0;                         // UBA1 ahead of UBA3
            else if (pendBefore[1])
               idx = 1;
            else
               idx = -1;
            if (idx < 0)
               reportError("memory cycle with no DMA pending");
            else
            begin
               compareValue($sformatf("dma addr UBA%0d", idx * 2 + 1),
                            expAddr[idx], memCycle.addr);
               compareValue($sformatf("dma data UBA%0d", idx * 2 + 1),
                            expData[idx], memCycle.data);
               regModel[idx][0] = regModel[idx][0] + 1'b1;   // Next DMA address
               pending[idx]     = 1'b0;
            end
         end

         // DMA strobes, dropped while one is pending
         for (int d = 0; d < 2; d++)
         begin
            go = (d == 0) ? dmaGo1 : dmaGo3;
            if (go && !pendBefore[d])
            begin
               goCount++;
               pending[d]           = 1'b1;
               expAddr[d]           = regModel[d][0];
               expAddr[d][writeBit] = 1'b1;     // Always a write
               expData[d]           = regModel[d][1];
            end
         end

         //////////////////////////////
         // Closing summary
         //////////////////////////////

         if (endRun && !summaryDone)
         begin
            for (int d = 0; d < 2; d++)
            begin
               if (pending[d])
                  reportError($sformatf("UBA%0d DMA never reached memory", d * 2 + 1));
            end
            if (reqSeen)
               reportError("CPU request never completed");
            compareValue("memory writes per dmaGo", goCount, dmaCount);
            $display("Checker: %0d CPU ops, %0d DMA starts, %0d DMA writes, %0d errors",
                     cpuCount, goCount, dmaCount, errorCount);
            summaryDone <= 1'b1;
         end
      end
   end

endmodule

/* verilog/ubaBus.sv */
/*
   KS-10 I/O backplane
   Arbiter, bus mux and the two UBA devices, numbers 1 and 3
*/

`timescale 1ns/100ps

module ubaBus
#(
   parameter int ackTimeout = 16                // Target ack timeout
)
(
   input  logic                 clk,
   input  logic                 rst,
   // CPU port
   input  ks10BusPkg::busCycleT cpuCycle,
   output logic                 cpuAck,
   output ks10BusPkg::dataT     cpuRdata,
   output logic                 cpuNxm,
   // DMA strobes
   input  logic                 dmaGo1,
   input  logic                 dmaGo3,
   // Memory port
   output ks10BusPkg::busCycleT memCycle,
   input  logic                 memAck
);

   import ks10BusPkg::*;

   //////////////////////////////
   // Backplane nets
   //////////////////////////////

   busCycleT tgtCycle;                          // Arbiter broadcast
   busAckT   tgtAck;                            // Merged ack
   busCycleT dmaCycle;                          // Selected initiator
   logic     dmaAck;
   busCycleT tgt1, tgt3;                        // Broadcast copies
   busAckT   ack1, ack3;
   busCycleT init1, init3;
   logic     dmaAck1, dmaAck3;

   busArbiter #(
      .ackTimeout (ackTimeout)
   ) arbiter_inst (
      .clk      (clk),
      .rst      (rst),
      .cpuCycle (cpuCycle),
      .cpuAck   (cpuAck),
      .cpuNxm   (cpuNxm),
      .cpuRdata (cpuRdata),
      .tgtCycle (tgtCycle),
      .tgtAck   (tgtAck),
      .dmaCycle (dmaCycle),
      .memAck   (memAck),
      .memCycle (memCycle),
      .dmaAck   (dmaAck)
   );

   busMux mux_inst (
      .tgtCycle (tgtCycle),
      .tgtAck   (tgtAck),
      .dmaCycle (dmaCycle),
      .dmaAck   (dmaAck),
      .tgt1     (tgt1),
      .ack1     (ack1),
      .init1    (init1),
      .dmaAck1  (dmaAck1),
      .tgt3     (tgt3),
      .ack3     (ack3),
      .init3    (init3),
      .dmaAck3  (dmaAck3)
   );

   //////////////////////////////
   // UBA devices
   //////////////////////////////

   ubaDevice #(
      .ubaNum (1)
   ) uba1_inst (
      .clk       (clk),
      .rst       (rst),
      .tgtCycle  (tgt1),
      .tgtAck    (ack1),
      .dmaGo     (dmaGo1),
      .dmaAck    (dmaAck1),
      .initCycle (init1)
   );

   ubaDevice #(
      .ubaNum (3)
   ) uba3_inst (
      .clk       (clk),
      .rst       (rst),
      .tgtCycle  (tgt3),
      .tgtAck    (ack3),
      .dmaGo     (dmaGo3),
      .dmaAck    (dmaAck3),
      .initCycle (init3)
   );

endmodule

/* verilog/ubaDevice.sv */
/*
   UBA device
   Four-register bus target plus a single-word DMA write initiator.
   Register 0 holds the DMA address, register 1 the DMA data
*/

`timescale 1ns/100ps

module ubaDevice
#(
   parameter int ubaNum = 1                     // Device number on the bus
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  ks10BusPkg::busCycleT tgtCycle,       // Broadcast cycle
   output ks10BusPkg::busAckT   tgtAck,
   input  logic                 dmaGo,          // Start a DMA write
   input  logic                 dmaAck,         // DMA done
   output ks10BusPkg::busCycleT initCycle       // Our DMA request
);

   import ks10BusPkg::*;

   localparam devNumT myDev = devNumT'(ubaNum);

   dataT       regFile [4];
   logic       hit;                             // Addressed, not yet acked
   logic       isWrite;
   logic [1:0] regSel;
   addrT       dmaAddr;                         // Reg 0 with write flag

   //////////////////////////////
   // Target decode
   //////////////////////////////

   always_comb
   begin
      // Hold off a second ack while the arbiter drops req
      hit     = tgtCycle.req && !tgtAck.ack &&
                (tgtCycle.addr[devField +: $bits(devNumT)] == myDev);
      isWrite = tgtCycle.addr[writeBit];
      regSel  = tgtCycle.addr[regField +: 2];
      dmaAddr = regFile[0];
      dmaAddr[writeBit] = 1'b1;                 // DMA always writes
   end

   //////////////////////////////
   // Registers and DMA
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < 4; i++)
         begin
            regFile[i] <= '0;
         end
         tgtAck    <= '0;
         initCycle <= '0;
      end
      else
      begin
         tgtAck.ack <= hit;                     // One cycle after req
         if (hit)
            tgtAck.data <= isWrite ? '0 : regFile[regSel];

         // DMA initiator
         if (initCycle.req && dmaAck)
         begin
            initCycle.req <= 1'b0;              // Drops the cycle after ack
            regFile[0]    <= regFile[0] + 1'b1; // Next address
         end
         else if (dmaGo && !initCycle.req)      // Ignored while pending
         begin
            initCycle.req  <= 1'b1;
            initCycle.addr <= dmaAddr;
            initCycle.data <= regFile[1];
         end

         // CPU write on the ack edge, wins over the address increment
         if (hit && isWrite)
            regFile[regSel] <= tgtCycle.data;
      end
   end

   // Fields stay put until the arbiter answers
   dmaHold: assert property (@(posedge clk) disable iff (rst)
      initCycle.req && !dmaAck |=>
         initCycle.req && $stable(initCycle.addr) && $stable(initCycle.data));

endmodule

/* verilog/busMux.sv */
/*
   UBA bus multiplexer
   Fixed priority select of the DMA initiators, UBA1 over UBA3, and merge of
   the target acks. The arbiter broadcast goes to both devices
*/

`timescale 1ns/100ps

module busMux
(
   // Arbiter side
   input  ks10BusPkg::busCycleT tgtCycle,       // Broadcast from arbiter
   output ks10BusPkg::busAckT   tgtAck,         // Merged target ack
   output ks10BusPkg::busCycleT dmaCycle,       // Selected initiator
   input  logic                 dmaAck,
   // UBA1
   output ks10BusPkg::busCycleT tgt1,
   input  ks10BusPkg::busAckT   ack1,
   input  ks10BusPkg::busCycleT init1,
   output logic                 dmaAck1,
   // UBA3
   output ks10BusPkg::busCycleT tgt3,
   input  ks10BusPkg::busAckT   ack3,
   input  ks10BusPkg::busCycleT init3,
   output logic                 dmaAck3
);

   import ks10BusPkg::*;

   //////////////////////////////
   // Initiator select
   //////////////////////////////

   always_comb
   begin
      if (init1.req)
      begin
         dmaCycle = init1;                      // UBA1 wins
         dmaAck1  = dmaAck;
         dmaAck3  = 1'b0;
      end
      else
      begin
         dmaCycle = init3;                      // req low when idle too
         dmaAck1  = 1'b0;
         dmaAck3  = dmaAck;
      end
   end

   //////////////////////////////
   // Target ack merge
   //////////////////////////////

   always_comb
   begin
      if (ack1.ack)
         tgtAck = ack1;
      else
         tgtAck = ack3;
      tgt1 = tgtCycle;                          // Broadcast
      tgt3 = tgtCycle;
   end

   // Device numbers differ, so one target at most
   always_comb
   begin
      ackOneHot: assert final (!(ack1.ack && ack3.ack));
   end

endmodule

/* verilog/busArbiter.sv */
/*
   KS-10 bus arbiter
   Grants the backplane to the CPU or one UBA DMA initiator at a time.
   Unanswered CPU cycles time out and complete as NXM
*/

`timescale 1ns/100ps

module busArbiter
#(
   parameter int ackTimeout = 16                // Cycles to wait for a target ack
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  ks10BusPkg::busCycleT cpuCycle,       // Held until cpuAck
   output logic                 cpuAck,         // One cycle
   output logic                 cpuNxm,         // Valid with cpuAck
   output ks10BusPkg::dataT     cpuRdata,       // Valid with cpuAck
   output ks10BusPkg::busCycleT tgtCycle,       // Broadcast to the devices
   input  ks10BusPkg::busAckT   tgtAck,         // Merged device acks
   input  ks10BusPkg::busCycleT dmaCycle,       // Winning DMA initiator
   input  logic                 memAck,
   output ks10BusPkg::busCycleT memCycle,       // To external memory
   output logic                 dmaAck          // Back to the mux
);

   import ks10BusPkg::*;

   localparam int timerW = $clog2(ackTimeout + 1);

   arbStateT          state;
   addrT              cpuAddr;                  // Latched CPU cycle
   dataT              cpuWdata;
   logic [timerW-1:0] timer;                    // Cycles without ack

   //////////////////////////////
   // CPU cycle latch
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (state == arbIdle)
      begin
         cpuAddr  <= cpuCycle.addr;             // Frozen once arbCpu starts
         cpuWdata <= cpuCycle.data;
      end
   end

   //////////////////////////////
   // Arbiter FSM
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state    <= arbIdle;
         timer    <= '0;
         cpuAck   <= 1'b0;
         cpuNxm   <= 1'b0;
         cpuRdata <= '0;
      end
      else
      begin
         cpuAck <= 1'b0;                        // Default low
         case (state)
            arbIdle:
            begin
               timer <= '0;
               // The request is still high in the cycle of its own ack
               if (cpuCycle.req && !cpuAck)
                  state <= arbCpu;              // CPU first
               else if (dmaCycle.req)
                  state <= arbDma;
            end
            arbCpu:
            begin
               if (tgtAck.ack)
               begin
                  cpuRdata <= tgtAck.data;
                  cpuNxm   <= 1'b0;
                  state    <= arbDone;
               end
               else if (timer == timerW'(ackTimeout - 1))
               begin
                  cpuRdata <= '0;               // Nobody home
                  cpuNxm   <= 1'b1;
                  state    <= arbDone;
               end
               else
               begin
                  timer <= timer + 1'b1;
               end
            end
            arbDma:
            begin
               if (memAck)                      // No timeout on memory
                  state <= arbIdle;
            end
            arbDone:
            begin
               cpuAck <= 1'b1;
               state  <= arbIdle;
            end
            default:
            begin
               state <= arbIdle;
            end
         endcase
      end
   end

   //////////////////////////////
   // Bus outputs
   //////////////////////////////

   always_comb
   begin
      tgtCycle.req  = (state == arbCpu);
      tgtCycle.addr = cpuAddr;
      tgtCycle.data = cpuWdata;
      // Memory follows the mux winner, so UBA1 can take over a pending
      // DMA. Memory commits the cycle it sees together with memAck
      memCycle.req  = (state == arbDma);
      memCycle.addr = dmaCycle.addr;
      memCycle.data = dmaCycle.data;
      dmaAck        = (state == arbDma) && memAck;   // Same winner as memory saw
   end

   // Devices and memory never see a cycle at once
   busExclusive: assert property (@(posedge clk) disable iff (rst)
      !(tgtCycle.req && memCycle.req));

   // CPU completion is a single pulse
   cpuAckPulse: assert property (@(posedge clk) disable iff (rst)
      cpuAck |=> !cpuAck);

endmodule

/* verilog/ks10BusPkg.sv */
/*
   KS-10 backplane definitions
   Bus word types, cycle and acknowledge structs, address fields, arbiter states
*/

package ks10BusPkg;

   //////////////////////////////
   // Word types
   //////////////////////////////

   typedef logic [0:35] addrT;             // KS-10 bit order, bit 0 is MSB
   typedef logic [0:35] dataT;
   typedef logic [0:3]  devNumT;           // UBA device number

   // Address field positions
   parameter int writeBit = 0;             // Write flag
   parameter int devField = 14;            // Device number in bits 14 to 17
   parameter int regField = 34;            // Register select in bits 34 and 35

   //////////////////////////////
   // Bus structs
   //////////////////////////////

   // Cycle from an initiator, or the arbiter broadcast
   typedef struct packed
   {
      logic req;                           // Level, held until ack
      addrT addr;
      dataT data;                          // Write data
   } busCycleT;

   // Target acknowledge
   typedef struct packed
   {
      logic ack;                           // One cycle pulse
      dataT data;                          // Read data
   } busAckT;

   // Arbiter FSM
   typedef enum logic [1:0]
   {
      arbIdle,                             // Waiting for an initiator
      arbCpu,                              // CPU cycle out to the devices
      arbDma,                              // DMA cycle out to memory
      arbDone                              // CPU result registered
   } arbStateT;

endpackage
